// ==== qr_iter_config.svh ====
`ifndef QR_ITER_CONFIG_SVH
`define QR_ITER_CONFIG_SVH

// Matrix geometry and fixed-point format
`define QR_N        4
`define QR_ELEM_W   32
`define QR_FRAC_W   24

// AXI4-Lite register map in byte offsets
`define QR_ADDR_W   9
`define QR_R_BASE   9'h000
`define QR_Q_BASE   9'h040
`define QR_A_BASE   9'h080
`define QR_U_BASE   9'h0C0
`define QR_D_BASE   9'h100
`define QR_CTRL     9'h110
`define QR_STATUS   9'h114

// CTRL and STATUS bit positions
`define QR_CMD_STEP     0
`define QR_CMD_FINISH   1
`define QR_CMD_CLEAR    2
`define QR_ST_BUSY      0
`define QR_ST_DONE      1

`endif

// ==== qr_iter_pkg.sv ====
`default_nettype none

`include "qr_iter_config.svh"

package qr_iter_pkg;

    typedef logic signed [`QR_ELEM_W-1:0]   elem_t;
    typedef logic signed [2*`QR_ELEM_W-1:0] prod_t;
    typedef logic [$clog2(`QR_N*`QR_N)-1:0] idx_t;
    typedef logic [`QR_ADDR_W-1:0]          axi_addr_t;
    typedef logic [`QR_ELEM_W-1:0]          axi_data_t;

    // Indexed as e[row][col]
    typedef struct packed {
        elem_t [`QR_N-1:0][`QR_N-1:0] e;
    } mat_t;

    typedef struct packed {
        elem_t [`QR_N-1:0] d;
    } diag_t;

    typedef enum logic {
        PROD_A = 1'b0,
        PROD_U = 1'b1
    } mm_sel_t;

    typedef struct packed {
        logic    valid;
        mm_sel_t sel;
        idx_t    idx;
    } mm_req_t;

    // Result tagged with the request that produced it
    typedef struct packed {
        logic    valid;
        mm_sel_t sel;
        idx_t    idx;
        elem_t   value;
    } mm_wb_t;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        DRAIN,
        COMMIT,
        SORT,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== qr_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_iter_config.svh"

module qr_axil_regs
    import qr_iter_pkg::*;
(
    input  wire             CLK_QR,
    input  wire             GO_QR,
    input  wire axi_addr_t  s_axil_awaddr,
    input  wire             s_axil_awvalid,
    output logic            s_axil_awready,
    input  wire axi_data_t  s_axil_wdata,
    input  wire             s_axil_wvalid,
    output logic            s_axil_wready,
    output logic [1:0]      s_axil_bresp,
    output logic            s_axil_bvalid,
    input  wire             s_axil_bready,
    input  wire axi_addr_t  s_axil_araddr,
    input  wire             s_axil_arvalid,
    output logic            s_axil_arready,
    output axi_data_t       s_axil_rdata,
    output logic [1:0]      s_axil_rresp,
    output logic            s_axil_rvalid,
    input  wire             s_axil_rready,
    input  wire             busy,
    input  wire             done,
    output logic            cmd_step,
    output logic            cmd_finish,
    output logic            cmd_clear,
    input  wire             commit,
    input  wire mm_wb_t     wb,
    input  wire diag_t      sorted_d,
    input  wire mat_t       sorted_e,
    input  wire             sort_done,
    output mat_t            r_mat,
    output mat_t            q_mat,
    output mat_t            u_mat
);

    mat_t       a_mat;
    mat_t       u_shadow;
    diag_t      d_reg;
    logic       wr_fire;
    logic       rd_fire;
    logic       data_wr;
    logic       ctrl_wr;
    axi_addr_t  wr_base;
    axi_addr_t  rd_base;
    idx_t       wr_idx;
    idx_t       rd_idx;
    axi_data_t  rd_word;
    axi_data_t  status_word;

    function automatic mat_t identity_mat();
        mat_t m;
        m = '0;
        for (int i = 0; i < `QR_N; i++)
        begin
            m.e[i][i] = elem_t'(1) <<< `QR_FRAC_W;
        end
        return m;
    endfunction

    // Both write channels must be present, and the last response taken
    assign wr_fire        = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign s_axil_bresp   = 2'b00;
    assign rd_fire        = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = !s_axil_rvalid;
    assign s_axil_rresp   = 2'b00;

    assign wr_base = {s_axil_awaddr[8:6], 6'd0};
    assign rd_base = {s_axil_araddr[8:6], 6'd0};
    assign wr_idx  = s_axil_awaddr[5:2];
    assign rd_idx  = s_axil_araddr[5:2];

    // Operand banks are frozen while a step or sort runs
    assign data_wr    = wr_fire && !busy;
    assign ctrl_wr    = data_wr && (s_axil_awaddr == `QR_CTRL);
    assign cmd_step   = ctrl_wr && s_axil_wdata[`QR_CMD_STEP];
    assign cmd_finish = ctrl_wr && s_axil_wdata[`QR_CMD_FINISH]
                        && !s_axil_wdata[`QR_CMD_STEP];
    assign cmd_clear  = ctrl_wr && s_axil_wdata[`QR_CMD_CLEAR]
                        && !s_axil_wdata[`QR_CMD_STEP] && !s_axil_wdata[`QR_CMD_FINISH];

    always_comb
    begin
        status_word = '0;
        status_word[`QR_ST_BUSY] = busy;
        status_word[`QR_ST_DONE] = done;
    end

    always_comb
    begin
        rd_word = '0;
        case (rd_base)
            `QR_R_BASE: rd_word = r_mat.e[rd_idx[3:2]][rd_idx[1:0]];
            `QR_Q_BASE: rd_word = q_mat.e[rd_idx[3:2]][rd_idx[1:0]];
            `QR_A_BASE: rd_word = a_mat.e[rd_idx[3:2]][rd_idx[1:0]];
            `QR_U_BASE: rd_word = u_mat.e[rd_idx[3:2]][rd_idx[1:0]];
            default:
            begin
                if ({s_axil_araddr[8:4], 4'd0} == `QR_D_BASE)
                    rd_word = d_reg.d[s_axil_araddr[3:2]];
                else if (s_axil_araddr == `QR_STATUS)
                    rd_word = status_word;
            end
        endcase
    end

    always_ff @(posedge CLK_QR or negedge GO_QR)
    begin
        if (!GO_QR)
        begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end
        else
        begin
            if (wr_fire)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
            if (rd_fire)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;
        end
    end

    // Read data held until the response is taken
    always_ff @(posedge CLK_QR)
    begin
        if (rd_fire)
            s_axil_rdata <= rd_word;
    end

    always_ff @(posedge CLK_QR or negedge GO_QR)
    begin
        if (!GO_QR)
        begin
            r_mat <= '0;
            q_mat <= '0;
            a_mat <= '0;
            u_mat <= identity_mat();
            d_reg <= '0;
        end
        else
        begin
            if (data_wr && wr_base == `QR_R_BASE)
                r_mat.e[wr_idx[3:2]][wr_idx[1:0]] <= elem_t'(s_axil_wdata);
            if (data_wr && wr_base == `QR_Q_BASE)
                q_mat.e[wr_idx[3:2]][wr_idx[1:0]] <= elem_t'(s_axil_wdata);
            if (wb.valid && wb.sel == PROD_A)
                a_mat.e[wb.idx[3:2]][wb.idx[1:0]] <= wb.value;
            if (cmd_clear)
                u_mat <= identity_mat();
            else if (commit)
                u_mat <= u_shadow;
            else if (sort_done)
                u_mat <= sorted_e;
            if (sort_done)
                d_reg <= sorted_d;
        end
    end

    // New U builds up here while the old one still feeds the products
    always_ff @(posedge CLK_QR)
    begin
        if (wb.valid && wb.sel == PROD_U)
            u_shadow.e[wb.idx[3:2]][wb.idx[1:0]] <= wb.value;
    end

endmodule

`default_nettype wire

// ==== qr_step_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module qr_step_ctrl
    import qr_iter_pkg::*;
(
    input  wire     CLK_QR,
    input  wire     GO_QR,
    input  wire     cmd_step,
    input  wire     cmd_finish,
    input  wire     cmd_clear,
    input  wire     sort_done,
    output mm_req_t req,
    output logic    commit,
    output logic    sort_start,
    output logic    busy,
    output logic    done
);

    ctrl_state_t state;
    logic [4:0]  cnt;

    always_ff @(posedge CLK_QR or negedge GO_QR)
    begin
        if (!GO_QR)
        begin
            state <= IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                IDLE, DONE:
                begin
                    cnt <= '0;
                    if (cmd_step)
                        state <= ISSUE;
                    else if (cmd_finish)
                        state <= SORT;
                    else if (cmd_clear)
                        state <= IDLE;
                end
                ISSUE:
                begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31)
                        state <= DRAIN;
                end
                // Last writeback lands here
                DRAIN:   state <= COMMIT;
                COMMIT:  state <= IDLE;
                SORT:
                begin
                    cnt <= cnt + 5'd1;
                    if (sort_done)
                        state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // First 16 requests build A, the next 16 build U
    assign req.valid  = (state == ISSUE);
    assign req.sel    = mm_sel_t'(cnt[4]);
    assign req.idx    = cnt[3:0];
    assign commit     = (state == COMMIT);
    assign sort_start = (state == SORT) && (cnt == 5'd0);
    assign busy       = (state == ISSUE) || (state == DRAIN)
                        || (state == COMMIT) || (state == SORT);
    assign done       = (state == DONE);

endmodule

`default_nettype wire

// ==== qr_matmul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_iter_config.svh"

module qr_matmul_unit
    import qr_iter_pkg::*;
(
    input  wire          CLK_QR,
    input  wire          GO_QR,
    input  wire mm_req_t req,
    input  wire mat_t    r_mat,
    input  wire mat_t    q_mat,
    input  wire mat_t    u_mat,
    output mm_wb_t       wb
);

    mat_t       lhs;
    logic [1:0] row;
    logic [1:0] col;
    prod_t      acc;
    prod_t      scaled;
    logic       wb_valid_q;
    mm_sel_t    wb_sel_q;
    idx_t       wb_idx_q;
    elem_t      wb_val_q;

    // Left operand is R for A = R*Q, U for U = U*Q
    assign lhs = (req.sel == PROD_A) ? r_mat : u_mat;
    assign row = req.idx[3:2];
    assign col = req.idx[1:0];

    always_comb
    begin
        acc = '0;
        for (int k = 0; k < `QR_N; k++)
        begin
            acc = acc + prod_t'(lhs.e[row][k]) * prod_t'(q_mat.e[k][col]);
        end
    end

    // Truncate toward minus infinity
    assign scaled = acc >>> `QR_FRAC_W;

    always_ff @(posedge CLK_QR or negedge GO_QR)
    begin
        if (!GO_QR)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= req.valid;
    end

    always_ff @(posedge CLK_QR)
    begin
        wb_sel_q <= req.sel;
        wb_idx_q <= req.idx;
        wb_val_q <= scaled[`QR_ELEM_W-1:0];
    end

    assign wb = '{valid: wb_valid_q, sel: wb_sel_q, idx: wb_idx_q, value: wb_val_q};

endmodule

`default_nettype wire

// ==== qr_eigen_sort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_iter_config.svh"

module qr_eigen_sort
    import qr_iter_pkg::*;
(
    input  wire       CLK_QR,
    input  wire       GO_QR,
    input  wire       sort_start,
    input  wire mat_t r_mat,
    input  wire mat_t u_mat,
    output diag_t     sorted_d,
    output mat_t      sorted_e,
    output logic      sort_done
);

    diag_t      d_work;
    diag_t      d_nxt;
    mat_t       e_work;
    mat_t       e_nxt;
    logic       active;
    logic [2:0] step;
    logic [1:0] pos;
    logic [1:0] pos_nx;

    // Bubble order 0-1, 1-2, 2-3, 0-1, 1-2, 0-1
    always_comb
    begin
        case (step)
            3'd1, 3'd4: pos = 2'd1;
            3'd2:       pos = 2'd2;
            default:    pos = 2'd0;
        endcase
    end

    assign pos_nx = pos + 2'd1;

    // Strict compare keeps ties in place
    always_comb
    begin
        d_nxt = d_work;
        e_nxt = e_work;
        if (d_work.d[pos] > d_work.d[pos_nx])
        begin
            d_nxt.d[pos]    = d_work.d[pos_nx];
            d_nxt.d[pos_nx] = d_work.d[pos];
            for (int r = 0; r < `QR_N; r++)
            begin
                e_nxt.e[r][pos]    = e_work.e[r][pos_nx];
                e_nxt.e[r][pos_nx] = e_work.e[r][pos];
            end
        end
    end

    always_ff @(posedge CLK_QR or negedge GO_QR)
    begin
        if (!GO_QR)
        begin
            active    <= 1'b0;
            step      <= '0;
            sort_done <= 1'b0;
        end
        else
        begin
            sort_done <= 1'b0;
            if (sort_start)
            begin
                active <= 1'b1;
                step   <= '0;
            end
            else if (active)
            begin
                step <= step + 3'd1;
                if (step == 3'd5)
                begin
                    active    <= 1'b0;
                    sort_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK_QR)
    begin
        if (sort_start)
        begin
            for (int i = 0; i < `QR_N; i++)
            begin
                d_work.d[i] <= r_mat.e[i][i];
            end
            e_work <= u_mat;
        end
        else if (active)
        begin
            d_work <= d_nxt;
            e_work <= e_nxt;
        end
    end

    assign sorted_d = d_work;
    assign sorted_e = e_work;

endmodule

`default_nettype wire

// ==== qr_iter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module qr_iter_top
    import qr_iter_pkg::*;
(
    input  wire             CLK_QR,
    input  wire             GO_QR,
    input  wire axi_addr_t  s_axil_awaddr,
    input  wire             s_axil_awvalid,
    output logic            s_axil_awready,
    input  wire axi_data_t  s_axil_wdata,
    input  wire             s_axil_wvalid,
    output logic            s_axil_wready,
    output logic [1:0]      s_axil_bresp,
    output logic            s_axil_bvalid,
    input  wire             s_axil_bready,
    input  wire axi_addr_t  s_axil_araddr,
    input  wire             s_axil_arvalid,
    output logic            s_axil_arready,
    output axi_data_t       s_axil_rdata,
    output logic [1:0]      s_axil_rresp,
    output logic            s_axil_rvalid,
    input  wire             s_axil_rready
);

    logic    busy;
    logic    done;
    logic    cmd_step;
    logic    cmd_finish;
    logic    cmd_clear;
    logic    commit;
    logic    sort_start;
    logic    sort_done;
    mm_req_t req;
    mm_wb_t  wb;
    mat_t    r_mat;
    mat_t    q_mat;
    mat_t    u_mat;
    mat_t    sorted_e;
    diag_t   sorted_d;

    qr_axil_regs u_regs (
        .CLK_QR         (CLK_QR),
        .GO_QR          (GO_QR),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .busy           (busy),
        .done           (done),
        .cmd_step       (cmd_step),
        .cmd_finish     (cmd_finish),
        .cmd_clear      (cmd_clear),
        .commit         (commit),
        .wb             (wb),
        .sorted_d       (sorted_d),
        .sorted_e       (sorted_e),
        .sort_done      (sort_done),
        .r_mat          (r_mat),
        .q_mat          (q_mat),
        .u_mat          (u_mat)
    );

    qr_step_ctrl u_ctrl (
        .CLK_QR     (CLK_QR),
        .GO_QR      (GO_QR),
        .cmd_step   (cmd_step),
        .cmd_finish (cmd_finish),
        .cmd_clear  (cmd_clear),
        .sort_done  (sort_done),
        .req        (req),
        .commit     (commit),
        .sort_start (sort_start),
        .busy       (busy),
        .done       (done)
    );

    qr_matmul_unit u_matmul (
        .CLK_QR (CLK_QR),
        .GO_QR  (GO_QR),
        .req    (req),
        .r_mat  (r_mat),
        .q_mat  (q_mat),
        .u_mat  (u_mat),
        .wb     (wb)
    );

    qr_eigen_sort u_sort (
        .CLK_QR     (CLK_QR),
        .GO_QR      (GO_QR),
        .sort_start (sort_start),
        .r_mat      (r_mat),
        .u_mat      (u_mat),
        .sorted_d   (sorted_d),
        .sorted_e   (sorted_e),
        .sort_done  (sort_done)
    );

endmodule

`default_nettype wire

// ==== qr_iter_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module qr_iter_sva
    import qr_iter_pkg::*;
(
    input wire            CLK_QR,
    input wire            GO_QR,
    input wire            s_axil_bvalid,
    input wire            s_axil_bready,
    input wire            s_axil_rvalid,
    input wire            s_axil_rready,
    input wire axi_data_t s_axil_rdata,
    input wire            busy,
    input wire            ctrl_wr
);

    bvalid_hold: assert property (@(posedge CLK_QR) disable iff (!GO_QR)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge CLK_QR) disable iff (!GO_QR)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

    rdata_stable: assert property (@(posedge CLK_QR) disable iff (!GO_QR)
        s_axil_rvalid && !s_axil_rready |=> $stable(s_axil_rdata))
        else $error("rdata changed while rvalid waited");

    // Busy only ever starts from an accepted CTRL write
    busy_cause: assert property (@(posedge CLK_QR) disable iff (!GO_QR)
        $rose(busy) |-> $past(ctrl_wr))
        else $error("busy rose without a CTRL write");

endmodule

`default_nettype wire

// ==== tb_qr_iter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_iter_config.svh"

module tb_qr_iter
    import qr_iter_pkg::*;
();

    // 40 ns clock
    localparam int HALF_PERIOD = 20;
    // Limit covers five tests of about 120 bus accesses of a few cycles each
    localparam int MAX_CYCLES = 20000;
    localparam elem_t ONE = elem_t'(1) <<< `QR_FRAC_W;

    typedef elem_t mat16_t [16];

    logic       CLK_QR;
    logic       GO_QR;
    axi_addr_t  s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axi_data_t  s_axil_wdata;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axi_addr_t  s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axi_data_t  s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;

    int     seed = 39;
    int     cycle_count = 0;
    mat16_t r_m;
    mat16_t q_m;
    mat16_t u_m;
    mat16_t a_m;

    qr_iter_top dut (
        .CLK_QR         (CLK_QR),
        .GO_QR          (GO_QR),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

    bind qr_axil_regs qr_iter_sva u_sva (
        .CLK_QR        (CLK_QR),
        .GO_QR         (GO_QR),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready),
        .s_axil_rdata  (s_axil_rdata),
        .busy          (busy),
        .ctrl_wr       (ctrl_wr)
    );

    initial CLK_QR = 1'b0;

    always #(HALF_PERIOD) CLK_QR = ~CLK_QR;

    always @(posedge CLK_QR)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "Simulation stopped at the cycle limit");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic axil_write(input axi_addr_t addr, input axi_data_t data);
        @(negedge CLK_QR);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        // awready is combinational so it is sampled shortly before the rising edge
        #(HALF_PERIOD / 2);
        while (!s_axil_awready)
        begin
            @(negedge CLK_QR);
            #(HALF_PERIOD / 2);
        end
        check("wready", 32'(s_axil_wready), 32'h1);
        @(negedge CLK_QR);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            @(negedge CLK_QR);
        check("bresp", 32'(s_axil_bresp), 32'h0);
        s_axil_bready = 1'b1;
        @(negedge CLK_QR);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input axi_addr_t addr, output axi_data_t data);
        @(negedge CLK_QR);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        #(HALF_PERIOD / 2);
        while (!s_axil_arready)
        begin
            @(negedge CLK_QR);
            #(HALF_PERIOD / 2);
        end
        @(negedge CLK_QR);
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            @(negedge CLK_QR);
        data = s_axil_rdata;
        check("rresp", 32'(s_axil_rresp), 32'h0);
        s_axil_rready = 1'b1;
        @(negedge CLK_QR);
        s_axil_rready = 1'b0;
    endtask

    task automatic wait_idle();
        axi_data_t st;
        axil_read(`QR_STATUS, st);
        while (st[`QR_ST_BUSY])
            axil_read(`QR_STATUS, st);
    endtask

    task automatic run_command(input int bit_pos);
        axil_write(`QR_CTRL, axi_data_t'(1) << bit_pos);
        wait_idle();
    endtask

    // Fixed-point dot product floored to 24 fraction bits with the low word kept
    function automatic elem_t fixed_dot(input mat16_t lhs, input mat16_t rhs,
                                        input int row, input int col);
        longint acc;
        acc = 0;
        for (int k = 0; k < 4; k++)
            acc = acc + longint'(lhs[4 * row + k]) * longint'(rhs[4 * k + col]);
        return elem_t'(acc >>> `QR_FRAC_W);
    endfunction

    // Uniform in [-2.0, 2.0)
    function automatic elem_t random_elem();
        elem_t v;
        v = $random(seed);
        return v >>> 6;
    endfunction

    function automatic axi_addr_t elem_addr(input axi_addr_t base, input int i);
        return base + axi_addr_t'(4 * i);
    endfunction

    task automatic write_matrix(input axi_addr_t base, input mat16_t m);
        for (int i = 0; i < 16; i++)
            axil_write(elem_addr(base, i), m[i]);
    endtask

    task automatic check_matrix(input axi_addr_t base, input mat16_t m, input string name);
        axi_data_t word;
        for (int i = 0; i < 16; i++)
        begin
            axil_read(elem_addr(base, i), word);
            check($sformatf("%s[%0d][%0d]", name, i / 4, i % 4), word, m[i]);
        end
    endtask

    task automatic check_status(input axi_data_t exp);
        axi_data_t st;
        axil_read(`QR_STATUS, st);
        check("STATUS", st, exp);
    endtask

    task automatic set_identity_model();
        for (int i = 0; i < 16; i++)
            u_m[i] = (i / 4 == i % 4) ? ONE : elem_t'(0);
    endtask

    task automatic randomize_operands();
        for (int i = 0; i < 16; i++)
        begin
            r_m[i] = random_elem();
            q_m[i] = random_elem();
        end
        write_matrix(`QR_R_BASE, r_m);
        write_matrix(`QR_Q_BASE, q_m);
    endtask

    task automatic step_and_check();
        mat16_t u_next;
        for (int i = 0; i < 16; i++)
        begin
            a_m[i]    = fixed_dot(r_m, q_m, i / 4, i % 4);
            u_next[i] = fixed_dot(u_m, q_m, i / 4, i % 4);
        end
        run_command(`QR_CMD_STEP);
        check_status(32'h0);
        check_matrix(`QR_A_BASE, a_m, "A");
        u_m = u_next;
        check_matrix(`QR_U_BASE, u_m, "U");
    endtask

    task automatic check_reset_values();
        mat16_t zero_m;
        for (int i = 0; i < 16; i++)
            zero_m[i] = '0;
        set_identity_model();
        check_status(32'h0);
        check_matrix(`QR_U_BASE, u_m, "U");
        check_matrix(`QR_A_BASE, zero_m, "A");
    endtask

    task automatic first_step_gives_q();
        randomize_operands();
        step_and_check();
        check_matrix(`QR_U_BASE, q_m, "U");
    endtask

    task automatic second_step_chains_u();
        randomize_operands();
        step_and_check();
        // A is read-only
        axil_write(elem_addr(`QR_A_BASE, 5), 32'h1234_5678);
        check_matrix(`QR_A_BASE, a_m, "A");
    endtask

    task automatic finish_sorts_diagonal();
        mat16_t    e_exp;
        elem_t     d_exp [4];
        int        rank;
        axi_data_t word;
        // Two negatives and a tie at 1.0
        r_m[0]  = ONE;
        r_m[5]  = -(ONE <<< 1);
        r_m[10] = ONE;
        r_m[15] = -(ONE >>> 2);
        for (int i = 0; i < 4; i++)
            axil_write(elem_addr(`QR_R_BASE, 5 * i), r_m[5 * i]);
        // Final position is the count of smaller values plus earlier equal ones
        for (int i = 0; i < 4; i++)
        begin
            rank = 0;
            for (int j = 0; j < 4; j++)
            begin
                if (r_m[5 * j] < r_m[5 * i] || (r_m[5 * j] == r_m[5 * i] && j < i))
                    rank++;
            end
            d_exp[rank] = r_m[5 * i];
            for (int row = 0; row < 4; row++)
                e_exp[4 * row + rank] = u_m[4 * row + i];
        end
        run_command(`QR_CMD_FINISH);
        check_status(axi_data_t'(1) << `QR_ST_DONE);
        for (int i = 0; i < 4; i++)
        begin
            axil_read(`QR_D_BASE + axi_addr_t'(4 * i), word);
            check($sformatf("D[%0d]", i), word, d_exp[i]);
        end
        check_matrix(`QR_U_BASE, e_exp, "E");
        u_m = e_exp;
    endtask

    task automatic clear_restores_identity();
        run_command(`QR_CMD_CLEAR);
        check_status(32'h0);
        set_identity_model();
        check_matrix(`QR_U_BASE, u_m, "U");
        randomize_operands();
        step_and_check();
        check_matrix(`QR_U_BASE, q_m, "U");
    endtask

    initial
    begin
        GO_QR          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        repeat (2) @(negedge CLK_QR);
        GO_QR = 1'b1;
        check_reset_values();
        first_step_gives_q();
        second_step_chains_u();
        finish_sorts_diagonal();
        clear_restores_identity();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
qr_iter_pkg.sv
qr_axil_regs.sv
qr_step_ctrl.sv
qr_matmul_unit.sv
qr_eigen_sort.sv
qr_iter_top.sv
qr_iter_sva.sv
tb_qr_iter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the QR co-processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_qr_iter \
    -f verilog.f -o qr_iter_sim

out=$(./obj_dir/qr_iter_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"
then
    exit 0
fi
exit 1
